// ==== Makefile ====
# Verilator build and run of the division unit testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_division_unit
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= TEST OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== all.f ====
source/div_pkg.sv
source/div_if.sv
source/div_operand_conditioner.sv
source/div_control_fsm.sv
source/div_step_counter.sv
source/nr_divider_datapath.sv
source/div_result_fixup.sv
source/division_unit.sv
test/tb_clock_gen.sv
test/tb_division_unit.sv

// ==== source/div_control_fsm.sv ====
/*
 * Control FSM of the division unit: IDLE waits for an operation,
 * ITERATE runs the divider steps and FINISH hands the result over
 */

module div_control_fsm import div_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      clk_en_i,
    input  logic      data_valid_i,
    div_ctrl_if.fsm   ctrl,
    output logic      idle_o
);

    div_state_t state_q;
    div_state_t state_d;

    // ----------------------------------------------------------------------
    // Next state
    // ----------------------------------------------------------------------

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                // Accept a new operation only while idle
                if (data_valid_i) begin
                    state_d = ITERATE;
                end
            end
            ITERATE: begin
                // Counter flags the final step one cycle ahead
                if (ctrl.last) begin
                    state_d = FINISH;
                end
            end
            FINISH: begin
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else if (clk_en_i) begin
            state_q <= state_d;
        end
    end

    // ----------------------------------------------------------------------
    // Strobes
    // ----------------------------------------------------------------------

    // data_valid_i outside IDLE is simply dropped
    assign ctrl.load   = (state_q == IDLE) && data_valid_i;
    assign ctrl.step   = (state_q == ITERATE);
    assign ctrl.finish = (state_q == FINISH);
    assign idle_o      = (state_q == IDLE);

    // The unit is ready again right after it hands over a result, and the
    // counter is already off its last value so the next operation runs in full
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (clk_en_i && ctrl.finish) |=> ((state_q == IDLE) && !ctrl.last));

endmodule : div_control_fsm

// ==== source/div_if.sv ====
/*
 * Operand interface between conditioner, datapath and result fixup,
 * and the control strobe interface shared by the FSM and its consumers
 */

interface div_operand_if import div_pkg::*; ();

    // Magnitudes are combinational, taken from the current inputs
    data_t          dividend_mag;
    data_t          divisor_mag;

    // Everything below is captured on the acceptance edge
    logic           neg_quotient;
    logic           neg_remainder;
    logic           div_by_zero;
    div_operation_t operation;
    data_t          dividend_raw;

    modport producer (output dividend_mag, divisor_mag, neg_quotient, neg_remainder,
                      div_by_zero, operation, dividend_raw);
    modport datapath (input dividend_mag, divisor_mag);
    modport fixup    (input neg_quotient, neg_remainder, div_by_zero, operation, dividend_raw);

endinterface : div_operand_if


interface div_ctrl_if ();

    logic load;
    logic step;
    logic finish;
    logic last;

    modport fsm         (output load, step, finish, input last);
    modport counter     (input load, step, output last);
    modport datapath    (input load, step);
    modport conditioner (input load);
    modport fixup       (input finish);

endinterface : div_ctrl_if

// ==== source/div_operand_conditioner.sv ====
/*
 * Operand conditioner: signed operands become magnitudes for the
 * unsigned core, and the sign, operation and zero flags are kept
 */

module div_operand_conditioner import div_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              clk_en_i,
    input  data_t             dividend_i,
    input  data_t             divisor_i,
    input  div_operation_t    operation_i,
    div_ctrl_if.conditioner   ctrl,
    div_operand_if.producer   opnd
);

    logic is_signed;
    logic dividend_neg;
    logic divisor_neg;

    // DIV and REM treat both operands as two's complement
    assign is_signed    = (operation_i == DIV) || (operation_i == REM);
    assign dividend_neg = is_signed && dividend_i[DATA_WIDTH-1];
    assign divisor_neg  = is_signed && divisor_i[DATA_WIDTH-1];

    // Magnitudes go straight to the datapath, which loads them on the same edge
    assign opnd.dividend_mag = dividend_neg ? (~dividend_i + 1'b1) : dividend_i;
    assign opnd.divisor_mag  = divisor_neg  ? (~divisor_i + 1'b1)  : divisor_i;

    // ----------------------------------------------------------------------
    // Flags captured at acceptance
    // ----------------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            opnd.neg_quotient  <= 1'b0;
            opnd.neg_remainder <= 1'b0;
            opnd.div_by_zero   <= 1'b0;
            opnd.operation     <= DIVU;
        end else if (clk_en_i && ctrl.load) begin
            // Quotient is negative when exactly one operand is negative
            opnd.neg_quotient  <= dividend_neg ^ divisor_neg;
            // Remainder follows the sign of the dividend
            opnd.neg_remainder <= dividend_neg;
            opnd.div_by_zero   <= (divisor_i == '0);
            opnd.operation     <= operation_i;
        end
    end

    // Raw dividend is the REM result when the divisor is zero
    always_ff @(posedge clk_i) begin
        if (clk_en_i && ctrl.load) begin
            opnd.dividend_raw <= dividend_i;
        end
    end

    // The operation taken at acceptance must be a known encoding
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (clk_en_i && ctrl.load) |-> !$isunknown(operation_i));

endmodule : div_operand_conditioner

// ==== source/div_pkg.sv ====
/*
 * Shared definitions for the division unit: operand width, step count,
 * vector typedefs, the operation encoding and the FSM state encoding
 */

package div_pkg;

    // ----------------------------------------------------------------------
    // Sizes
    // ----------------------------------------------------------------------

    // Operand and result width of the RV32 datapath
    localparam int DATA_WIDTH = 32;

    // One non-restoring step per quotient bit
    localparam int DIV_STEPS = DATA_WIDTH;

    // Wide enough to count from 0 to DIV_STEPS - 1
    localparam int STEP_CNT_WIDTH = 5;

    // ----------------------------------------------------------------------
    // Types
    // ----------------------------------------------------------------------

    typedef logic [DATA_WIDTH-1:0]     data_t;
    typedef logic [STEP_CNT_WIDTH-1:0] step_cnt_t;

    // Partial remainder with one extra bit that carries its sign
    typedef logic [DATA_WIDTH:0]       rem_acc_t;

    // M-extension division operations
    typedef enum logic [1:0] {
        DIV,
        DIVU,
        REM,
        REMU
    } div_operation_t;

    typedef enum logic [1:0] {
        IDLE,
        ITERATE,
        FINISH
    } div_state_t;

endpackage : div_pkg

// ==== source/div_result_fixup.sv ====
/*
 * Result fixup: restores the signs, applies the RISC-V divide by zero
 * values, selects quotient or remainder and registers the outputs
 */

module div_result_fixup import div_pkg::*; (
    input  logic           clk_i,
    input  logic           rst_n_i,
    input  logic           clk_en_i,
    div_ctrl_if.fixup      ctrl,
    div_operand_if.fixup   opnd,
    input  data_t          quotient_i,
    input  data_t          remainder_i,
    output data_t          product_o,
    output logic           data_valid_o,
    output logic           divide_by_zero_o
);

    data_t quo_signed;
    data_t rem_signed;
    data_t result;

    // ----------------------------------------------------------------------
    // Sign restore and select
    // ----------------------------------------------------------------------

    // Most negative by minus one comes out right here, since the magnitude
    // quotient is already the most negative bit pattern and is not negated
    assign quo_signed = opnd.neg_quotient  ? (~quotient_i + 1'b1)  : quotient_i;
    assign rem_signed = opnd.neg_remainder ? (~remainder_i + 1'b1) : remainder_i;

    always_comb begin
        case (opnd.operation)
            DIV, DIVU: begin
                // Quotient of a division by zero is all ones
                result = opnd.div_by_zero ? '1 : quo_signed;
            end
            default: begin
                // Remainder of a division by zero is the untouched dividend
                result = opnd.div_by_zero ? opnd.dividend_raw : rem_signed;
            end
        endcase
    end

    // ----------------------------------------------------------------------
    // Output registers
    // ----------------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            data_valid_o     <= 1'b0;
            divide_by_zero_o <= 1'b0;
        end else if (clk_en_i) begin
            // Both flags are single cycle pulses alongside the result
            data_valid_o     <= ctrl.finish;
            divide_by_zero_o <= ctrl.finish && opnd.div_by_zero;
        end
    end

    // product_o keeps its value until the next result
    always_ff @(posedge clk_i) begin
        if (clk_en_i && ctrl.finish) begin
            product_o <= result;
        end
    end

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (clk_en_i && data_valid_o) |=> !data_valid_o);

endmodule : div_result_fixup

// ==== source/div_step_counter.sv ====
/*
 * Step counter: tracks the non-restoring iterations and
 * flags the last one so the FSM can leave ITERATE in time
 */

module div_step_counter import div_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_n_i,
    input  logic         clk_en_i,
    div_ctrl_if.counter  ctrl
);

    step_cnt_t count_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            count_q <= '0;
        end else if (clk_en_i) begin
            if (ctrl.load) begin
                count_q <= '0;
            end else if (ctrl.step) begin
                // Wraps back to zero after the final step
                count_q <= count_q + 1'b1;
            end
        end
    end

    // High during the cycle before the final step edge
    assign ctrl.last = (count_q == step_cnt_t'(DIV_STEPS - 1));

    // No further step may follow the last one
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (clk_en_i && ctrl.step && ctrl.last) |=> !ctrl.step);

endmodule : div_step_counter

// ==== source/division_unit.sv ====
/*
 * Integer division unit of the RV32 execute stage, DIV DIVU REM REMU.
 * Top level wiring of conditioner, FSM, counter, datapath and fixup
 */

module division_unit import div_pkg::*; (
    input  logic           clk_i,
    input  logic           clk_en_i,
    input  logic           rst_n_i,
    input  data_t          dividend_i,
    input  data_t          divisor_i,
    input  logic           data_valid_i,
    input  div_operation_t operation_i,
    output data_t          product_o,
    output logic           data_valid_o,
    output logic           divide_by_zero_o,
    output logic           idle_o
);

    data_t quotient;
    data_t remainder;

    div_ctrl_if    ctrl_if ();
    div_operand_if opnd_if ();

    // ----------------------------------------------------------------------
    // Control
    // ----------------------------------------------------------------------

    div_control_fsm fsm_inst (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .clk_en_i     (clk_en_i),
        .data_valid_i (data_valid_i),
        .ctrl         (ctrl_if.fsm),
        .idle_o       (idle_o)
    );

    div_step_counter counter_inst (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .clk_en_i (clk_en_i),
        .ctrl     (ctrl_if.counter)
    );

    // ----------------------------------------------------------------------
    // Data path
    // ----------------------------------------------------------------------

    div_operand_conditioner conditioner_inst (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .clk_en_i    (clk_en_i),
        .dividend_i  (dividend_i),
        .divisor_i   (divisor_i),
        .operation_i (operation_i),
        .ctrl        (ctrl_if.conditioner),
        .opnd        (opnd_if.producer)
    );

    nr_divider_datapath datapath_inst (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .clk_en_i    (clk_en_i),
        .ctrl        (ctrl_if.datapath),
        .opnd        (opnd_if.datapath),
        .quotient_o  (quotient),
        .remainder_o (remainder)
    );

    div_result_fixup fixup_inst (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .clk_en_i         (clk_en_i),
        .ctrl             (ctrl_if.fixup),
        .opnd             (opnd_if.fixup),
        .quotient_i       (quotient),
        .remainder_i      (remainder),
        .product_o        (product_o),
        .data_valid_o     (data_valid_o),
        .divide_by_zero_o (divide_by_zero_o)
    );

endmodule : division_unit

// ==== source/nr_divider_datapath.sv ====
/*
 * Non-restoring unsigned divider core: one shift and add or subtract
 * per step, with the remainder corrected once at the end
 */

module nr_divider_datapath import div_pkg::*; (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             clk_en_i,
    div_ctrl_if.datapath     ctrl,
    div_operand_if.datapath  opnd,
    output data_t            quotient_o,
    output data_t            remainder_o
);

    // Partial remainder, its top bit is the sign
    rem_acc_t rem_q;
    rem_acc_t rem_shift;
    rem_acc_t rem_next;

    // Holds the dividend bits first and fills up with quotient bits
    data_t quo_q;
    data_t divisor_q;

    // ----------------------------------------------------------------------
    // One iteration
    // ----------------------------------------------------------------------

    // Remainder and quotient shift left as one register pair
    assign rem_shift = {rem_q[DATA_WIDTH-1:0], quo_q[DATA_WIDTH-1]};

    // A negative remainder adds the divisor back, a positive one subtracts it.
    // The result always fits because the remainder stays in [-divisor, divisor)
    assign rem_next = rem_q[DATA_WIDTH] ? (rem_shift + {1'b0, divisor_q})
                                        : (rem_shift - {1'b0, divisor_q});

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rem_q <= '0;
        end else if (clk_en_i) begin
            if (ctrl.load) begin
                rem_q <= '0;
            end else if (ctrl.step) begin
                rem_q <= rem_next;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (clk_en_i) begin
            if (ctrl.load) begin
                quo_q     <= opnd.dividend_mag;
                divisor_q <= opnd.divisor_mag;
            end else if (ctrl.step) begin
                // New quotient bit is set when the remainder stays non-negative
                quo_q <= {quo_q[DATA_WIDTH-2:0], ~rem_next[DATA_WIDTH]};
            end
        end
    end

    // ----------------------------------------------------------------------
    // Final correction
    // ----------------------------------------------------------------------

    // The quotient bits are already exact in this form of the algorithm
    assign quotient_o = quo_q;

    // A negative final remainder gets one divisor added back.
    // With a zero divisor nothing is ever subtracted, so the dividend ends up here
    assign remainder_o = rem_q[DATA_WIDTH] ? (rem_q[DATA_WIDTH-1:0] + divisor_q)
                                           : rem_q[DATA_WIDTH-1:0];

endmodule : nr_divider_datapath

// ==== test/tb_clock_gen.sv ====
/*
 * Clock and reset source of the testbench: 40 ns clock,
 * active low reset held for a number of rising edges
 */

module tb_clock_gen #(
    parameter int RESET_CYCLES = 8
) (
    output logic clk_o,
    output logic rst_n_o
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_o = 1'b0;
        forever #20 clk_o = ~clk_o;
    end

    // Release lands 2 ns after an edge, away from the sampling point
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #2;
        rst_n_o = 1'b1;
    end

endmodule : tb_clock_gen

// ==== test/tb_division_unit.sv ====
/*
 * Testbench of the division unit: fixed vector table, LFSR random cases,
 * RISC-V reference model, compare tasks, cycle timeout and summary
 */

module tb_division_unit import div_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES = 8;
    // Enabled edges from acceptance to the result
    localparam int LATENCY      = 33;
    localparam int NUM_RANDOM   = 16;

    typedef struct {
        data_t          dividend;
        data_t          divisor;
        div_operation_t operation;
        logic [63:0]    gap_pattern;   // Bit n set means clk_en low in busy cycle n
        int             stray_cycle;   // Busy cycle with an extra request, -1 for none
        data_t          exp_product;
        logic           exp_zero;
    } entry_t;

    logic           clk;
    logic           rst_n;
    logic           clk_en;
    logic           valid_in;
    data_t          dividend;
    data_t          divisor;
    div_operation_t op;
    data_t          product;
    logic           valid_out;
    logic           div_zero;
    logic           idle;

    entry_t      vectors[$];
    logic [31:0] lfsr_state;
    int          error_count;
    int          pass_count;
    int          fail_count;
    int          cycle_count;
    int          cycle_limit;

    tb_clock_gen #(.RESET_CYCLES(RESET_CYCLES)) clock_inst (.clk_o(clk), .rst_n_o(rst_n));

    division_unit division_unit_inst (
        .clk_i            (clk),
        .clk_en_i         (clk_en),
        .rst_n_i          (rst_n),
        .dividend_i       (dividend),
        .divisor_i        (divisor),
        .data_valid_i     (valid_in),
        .operation_i      (op),
        .product_o        (product),
        .data_valid_o     (valid_out),
        .divide_by_zero_o (div_zero),
        .idle_o           (idle)
    );

    // ----------------------------------------------------------------------
    // Random numbers and reference model
    // ----------------------------------------------------------------------

    // Fibonacci LFSR x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic data_t random_bits(input int n);
        data_t value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[DATA_WIDTH-2:0], lfsr_bit()};
        end
        return value;
    endfunction

    // SV division truncates toward zero and the remainder keeps the dividend's sign
    function automatic data_t model_result(input data_t a, input data_t b,
                                           input div_operation_t operation);
        longint num;
        longint den;
        longint q;
        longint r;
        if (b == '0) begin
            return (operation == DIV || operation == DIVU) ? '1 : a;
        end
        if (operation == DIV || operation == REM) begin
            num = $signed(a);
            den = $signed(b);
        end else begin
            num = {32'b0, a};
            den = {32'b0, b};
        end
        q = num / den;
        r = num % den;
        return (operation == DIV || operation == DIVU) ? q[DATA_WIDTH-1:0] : r[DATA_WIDTH-1:0];
    endfunction

    // ----------------------------------------------------------------------
    // Vector table
    // ----------------------------------------------------------------------

    task automatic add_entry(input data_t a, input data_t b, input div_operation_t operation,
                             input logic [63:0] gap, input int stray, input data_t exp_p,
                             input logic exp_z);
        entry_t e;
        e.dividend    = a;
        e.divisor     = b;
        e.operation   = operation;
        e.gap_pattern = gap;
        e.stray_cycle = stray;
        e.exp_product = exp_p;
        e.exp_zero    = exp_z;
        vectors.push_back(e);
    endtask

    task automatic build_table();
        data_t          a;
        data_t          b;
        data_t          shift;
        data_t          op_bits;
        div_operation_t operation;
        // Unsigned, including a small dividend and an all-ones dividend
        add_entry(32'd100, 32'd7, DIVU, '0, -1, 32'd14, 1'b0);
        add_entry(32'd100, 32'd7, REMU, '0, -1, 32'd2, 1'b0);
        add_entry(32'd5, 32'd9, DIVU, '0, -1, 32'd0, 1'b0);
        add_entry(32'd5, 32'd9, REMU, '0, -1, 32'd5, 1'b0);
        add_entry(32'hFFFF_FFFF, 32'd1, DIVU, '0, -1, 32'hFFFF_FFFF, 1'b0);
        add_entry(32'hFFFF_FFFF, 32'd10, DIVU, '0, -1, 32'h1999_9999, 1'b0);
        add_entry(32'hFFFF_FFFF, 32'd10, REMU, '0, -1, 32'd5, 1'b0);
        // Signed, all four sign combinations of 20 and 3
        add_entry(32'd20, 32'd3, DIV, '0, -1, 32'd6, 1'b0);
        add_entry(32'd20, 32'd3, REM, '0, -1, 32'd2, 1'b0);
        add_entry(32'hFFFF_FFEC, 32'd3, DIV, '0, -1, 32'hFFFF_FFFA, 1'b0);
        add_entry(32'hFFFF_FFEC, 32'd3, REM, '0, -1, 32'hFFFF_FFFE, 1'b0);
        add_entry(32'd20, 32'hFFFF_FFFD, DIV, '0, -1, 32'hFFFF_FFFA, 1'b0);
        add_entry(32'd20, 32'hFFFF_FFFD, REM, '0, -1, 32'd2, 1'b0);
        add_entry(32'hFFFF_FFEC, 32'hFFFF_FFFD, DIV, '0, -1, 32'd6, 1'b0);
        add_entry(32'hFFFF_FFEC, 32'hFFFF_FFFD, REM, '0, -1, 32'hFFFF_FFFE, 1'b0);
        // Most negative by minus one
        add_entry(32'h8000_0000, 32'hFFFF_FFFF, DIV, '0, -1, 32'h8000_0000, 1'b0);
        add_entry(32'h8000_0000, 32'hFFFF_FFFF, REM, '0, -1, 32'd0, 1'b0);
        // Divide by zero under every operation
        add_entry(32'h4D2, 32'd0, DIV, '0, -1, 32'hFFFF_FFFF, 1'b1);
        add_entry(32'h4D2, 32'd0, DIVU, '0, -1, 32'hFFFF_FFFF, 1'b1);
        add_entry(32'hFFFF_FFFB, 32'd0, REM, '0, -1, 32'hFFFF_FFFB, 1'b1);
        add_entry(32'h4D2, 32'd0, REMU, '0, -1, 32'h4D2, 1'b1);
        // Clock enable gaps and requests while busy
        add_entry(32'd1000, 32'd33, DIVU, 64'h7, -1, 32'd30, 1'b0);
        add_entry(32'd1000, 32'd33, REMU, 64'h3_0000_0F00, -1, 32'd10, 1'b0);
        add_entry(32'hFFFF_FFF9, 32'd2, DIV, 64'h1_8000_0000, -1, 32'hFFFF_FFFD, 1'b0);
        add_entry(32'd7, 32'hFFFF_FFFE, REM, '0, 5, 32'd1, 1'b0);
        add_entry(32'd1000, 32'd33, REMU, 64'hF0, 20, 32'd10, 1'b0);
        // Random operands, the divisor shifted down to vary its size
        for (int i = 0; i < NUM_RANDOM; i++) begin
            a         = random_bits(32);
            b         = random_bits(32);
            shift     = random_bits(5);
            b         = b >> shift;
            op_bits   = random_bits(2);
            operation = div_operation_t'(op_bits[1:0]);
            add_entry(a, b, operation, '0, -1, model_result(a, b, operation), b == '0);
        end
    endtask

    // ----------------------------------------------------------------------
    // Compare tasks
    // ----------------------------------------------------------------------

    task automatic check_product(input data_t got, input data_t exp, input string what);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            error_count++;
        end
    endtask

    // ----------------------------------------------------------------------
    // One operation, from acceptance to its result
    // ----------------------------------------------------------------------

    task automatic run_entry(input int idx);
        entry_t e;
        int     enabled;
        int     busy_cycle;
        int     errors_before;
        e             = vectors[idx];
        errors_before = error_count;
        check_flag(idle, 1'b1, "idle_o before acceptance");
        dividend = e.dividend;
        divisor  = e.divisor;
        op       = e.operation;
        valid_in = 1'b1;
        clk_en   = 1'b1;
        @(posedge clk);
        #2;
        // The previous result pulse ends on the acceptance edge
        check_flag(valid_out, 1'b0, "data_valid_o after acceptance");
        check_flag(idle, 1'b0, "idle_o after acceptance");
        enabled    = 0;
        busy_cycle = 0;
        while (enabled < LATENCY) begin
            clk_en = !e.gap_pattern[busy_cycle[5:0]];
            if (busy_cycle == e.stray_cycle) begin
                // Different operands so a wrongly accepted request shows up in the result
                dividend = ~e.dividend;
                divisor  = e.divisor + 1'b1;
                op       = (e.operation == DIV) ? REMU : DIV;
                valid_in = 1'b1;
            end else begin
                valid_in = 1'b0;
            end
            @(posedge clk);
            if (clk_en) begin
                enabled++;
            end
            #2;
            if (enabled < LATENCY) begin
                check_flag(valid_out, 1'b0, "data_valid_o before the result");
                check_flag(idle, 1'b0, "idle_o while busy");
            end
            busy_cycle++;
        end
        valid_in = 1'b0;
        check_flag(valid_out, 1'b1, "data_valid_o at the result");
        check_flag(idle, 1'b1, "idle_o at the result");
        check_product(product, e.exp_product, "product_o");
        check_flag(div_zero, e.exp_zero, "divide_by_zero_o");
        if (error_count == errors_before) begin
            pass_count++;
        end else begin
            fail_count++;
        end
        $display("test %0d: %s %h, %h -> %h, %0d disabled cycles: %s", idx,
                 e.operation.name(), e.dividend, e.divisor, product, busy_cycle - LATENCY,
                 (error_count == errors_before) ? "pass" : "fail");
    endtask

    // ----------------------------------------------------------------------
    // Main sequence and timeout
    // ----------------------------------------------------------------------

    initial begin
        clk_en      = 1'b1;
        valid_in    = 1'b0;
        dividend    = '0;
        divisor     = '0;
        op          = DIVU;
        error_count = 0;
        pass_count  = 0;
        fail_count  = 0;
        lfsr_state  = 32'd82236;
        build_table();
        // Each entry takes at most 40 cycles on average, gaps included
        cycle_limit = vectors.size() * 40 + RESET_CYCLES;
        wait (rst_n === 1'b1);
        @(posedge clk);
        #2;
        check_flag(idle, 1'b1, "idle_o after reset");
        check_flag(valid_out, 1'b0, "data_valid_o after reset");
        check_flag(div_zero, 1'b0, "divide_by_zero_o after reset");
        for (int i = 0; i < vectors.size(); i++) begin
            run_entry(i);
        end
        // The last result must drop after one enabled cycle
        @(posedge clk);
        #2;
        check_flag(valid_out, 1'b0, "data_valid_o after the last result");
        $display("%0d tests run, %0d passed, %0d failed, %0d errors",
                 vectors.size(), pass_count, fail_count, error_count);
        if (error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        // The limit is set at time zero, before the first edge
        @(posedge clk);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the tests did not finish within %0d clock cycles", cycle_limit);
        $display("TEST FAILED");
        $finish;
    end

endmodule : tb_division_unit
